// File: filelist.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/exec_ctrl_if.sv
hdl/instr_decode.sv
hdl/alu_execute.sv
hdl/load_store_align.sv
hdl/hazard_unit.sv
hdl/pipeline_core.sv
testbench/core_checker.sv
testbench/tb_core.sv

// File: testbench/tb_core.sv
`include "rv_fields.svh"

module tb_core;
    import rv_isa_pkg::*;
    import core_pkg::*;

    localparam int         INIT_LEN  = 15;
    localparam int         BODY_LEN  = 200;
    localparam int         BODY_END  = INIT_LEN + BODY_LEN;
    localparam int         PROG_LEN  = BODY_END + 8;
    localparam int         HALT_PC   = 4 * (PROG_LEN - 1);
    localparam logic [4:0] BASE_REG  = 5'd8;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        fetch_valid;
    logic        mem_valid;
    logic        data_we;
    logic [31:0] instr;
    logic [31:0] data_in;
    logic [31:0] pc_out;
    logic [31:0] data_addr;
    logic [31:0] data_out;
    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] model_mem [0:255];
    integer      seed = 32'h3f189cf4;
    int          expected_stores = 0;

    always #50 clk = ~clk;

    pipeline_core UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr       (instr),
        .fetch_valid (fetch_valid),
        .data_in     (data_in),
        .mem_valid   (mem_valid),
        .pc_out      (pc_out),
        .data_addr   (data_addr),
        .data_out    (data_out),
        .data_we     (data_we)
    );

    core_checker chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .data_we   (data_we),
        .mem_valid (mem_valid),
        .data_addr (data_addr),
        .data_out  (data_out)
    );

    assign instr   = imem[pc_out[9:2]];
    assign data_in = dmem[data_addr[9:2]];

    always @(posedge clk) begin
        if (data_we && mem_valid)
            dmem[data_addr[9:2]] <= data_out;
    end

    // Roughly one cycle in five without valid
    always @(posedge clk) begin
        fetch_valid <= ($unsigned($random(seed)) % 5) != 0;
        mem_valid   <= ($unsigned($random(seed)) % 5) != 0;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h9e37_79b1) ^ 32'h0f0f_5a5a;
    endfunction

    task automatic gen_program();
        logic [31:0] rnd;
        logic [11:0] imm;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        int          idx;
        int          k;
        int          kind;
        for (idx = 0; idx < 256; idx++)
            imem[idx] = NOP_INSTR;
        idx = 0;
        for (k = 1; k < 8; k++) begin
            rnd = $random(seed);
            imem[idx]     = enc_u(rnd[31:12], k[4:0], OPC_LUI);
            imem[idx + 1] = enc_i(rnd[11:0], k[4:0], F3_ADD, k[4:0], OPC_OP_IMM);
            idx += 2;
        end
        imem[idx] = enc_i(12'h100, 5'd0, F3_ADD, BASE_REG, OPC_OP_IMM);
        idx++;
        while (idx < BODY_END) begin
            kind = $unsigned($random(seed)) % 12;
            rnd  = $random(seed);
            rd   = {2'b0, rnd[2:0]};
            rs1  = {2'b0, rnd[5:3]};
            rs2  = {2'b0, rnd[8:6]};
            f3   = rnd[11:9];
            // Forward jump of 1 to 4 instructions, never past the body
            k = 1 + rnd[31:30];
            if (idx + k > BODY_END)
                k = BODY_END - idx;
            boff = 4 * k;
            joff = 4 * k;
            case (kind)
                0, 1, 2: begin
                    imm[6:0] = ((f3 == F3_ADD || f3 == F3_SRL) && rnd[12]) ? 7'b0100000 : 7'b0;
                    imem[idx] = enc_r(imm[6:0], rs2, rs1, f3, rd);
                end
                3, 4: begin
                    if (f3 == F3_SLL)
                        imm = {7'b0, rnd[17:13]};
                    else if (f3 == F3_SRL)
                        imm = {1'b0, rnd[12], 5'b0, rnd[17:13]};
                    else
                        imm = rnd[23:12];
                    imem[idx] = enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
                end
                5: imem[idx] = enc_u(rnd[31:12], rd, rnd[9] ? OPC_LUI : OPC_AUIPC);
                6, 7: begin
                    f3 = rnd[11:9] % 5;
                    if (f3 > 3'd2)
                        f3 = f3 + 3'd1;
                    imem[idx] = enc_i({6'b0, rnd[17:12] & (6'h3f << f3[1:0])},
                                      BASE_REG, f3, rd, OPC_LOAD);
                end
                8: begin
                    f3 = {1'b0, rnd[10:9]} % 3;
                    imem[idx] = enc_s({6'b0, rnd[17:12] & (6'h3f << f3[1:0])},
                                      rs2, BASE_REG, f3);
                end
                9, 10: begin
                    f3 = rnd[11:9] % 6;
                    if (f3 > 3'd1)
                        f3 = f3 + 3'd2;
                    imem[idx] = enc_b(boff, rs2, rs1, f3);
                end
                default: imem[idx] = enc_j(joff, rd);
            endcase
            idx++;
        end
        for (k = 1; k < 8; k++) begin
            imm = 4 * (k - 1);
            imem[idx] = enc_s(imm, k[4:0], BASE_REG, F3_WORD);
            idx++;
        end
        // Self-branch ends the program
        imem[idx] = enc_b(13'd0, 5'd0, 5'd0, F3_BEQ);
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            F3_ADD:  r = alt ? a - b : a + b;
            F3_SLL:  r = a << b[4:0];
            F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_SLTU: r = (a < b) ? 32'd1 : 32'd0;
            F3_XOR:  r = a ^ b;
            F3_OR:   r = a | b;
            F3_AND:  r = a & b;
            default: begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
        endcase
        return r;
    endfunction

    function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] load_ref(input logic [2:0] f3, input logic [1:0] off,
                                             input logic [31:0] word);
        logic [31:0] sh;
        sh = word >> (8 * off);
        case (f3)
            F3_BYTE:   return {{24{sh[7]}}, sh[7:0]};
            F3_HALF:   return {{16{sh[15]}}, sh[15:0]};
            F3_BYTE_U: return {24'b0, sh[7:0]};
            F3_HALF_U: return {16'b0, sh[15:0]};
            default:   return word;
        endcase
    endfunction

    // Sub-word stores fill the whole word, no byte enables
    function automatic logic [31:0] store_word(input logic [2:0] f3, input logic [31:0] b);
        case (f3)
            F3_BYTE: return {4{b[7:0]}};
            F3_HALF: return {2{b[15:0]}};
            default: return b;
        endcase
    endfunction

    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        logic        wr;
        int          k;
        for (k = 0; k < 32; k++)
            regs[k] = '0;
        pc = '0;
        while (pc != HALT_PC) begin
            w       = imem[pc[9:2]];
            f3      = `FUNCT3(w);
            a       = regs[`RS1(w)];
            b       = regs[`RS2(w)];
            wr      = 1'b1;
            res     = '0;
            next_pc = pc + 32'd4;
            case (w[6:0])
                OPC_OP:     res = alu_ref(f3, w[30], a, b);
                OPC_OP_IMM: res = alu_ref(f3, f3 == F3_SRL && w[30], a,
                                          {{20{w[31]}}, w[31:20]});
                OPC_LUI:    res = {w[31:12], 12'b0};
                OPC_AUIPC:  res = pc + {w[31:12], 12'b0};
                OPC_JAL: begin
                    res     = pc + 32'd4;
                    next_pc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                end
                OPC_LOAD: begin
                    addr = a + {{20{w[31]}}, w[31:20]};
                    res  = load_ref(f3, addr[1:0], model_mem[addr[9:2]]);
                end
                OPC_STORE: begin
                    wr   = 1'b0;
                    addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                    word = store_word(f3, b);
                    model_mem[addr[9:2]] = word;
                    chk.expect_store(addr, word);
                    expected_stores++;
                end
                OPC_BRANCH: begin
                    wr = 1'b0;
                    if (branch_ref(f3, a, b))
                        next_pc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
                default: wr = 1'b0;
            endcase
            if (wr && `RD(w) != 5'd0)
                regs[`RD(w)] = res;
            pc = next_pc;
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        fetch_valid = 1'b0;
        mem_valid   = 1'b0;
        for (int i = 0; i < 256; i++) begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        gen_program();
        run_model();
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // Fetch reaches the self-branch once the last store is in flight
        wait (pc_out == HALT_PC);
        // Quiet period for the last stores and any late duplicate
        repeat (40) @(posedge clk);
        chk.check_drained();
        $display("%0d stores checked, %0d errors", chk.store_count, chk.error_count);
        if (chk.error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        repeat (20 * PROG_LEN) @(posedge clk);
        $display("Timeout: only %0d of %0d stores seen after %0d cycles",
                 chk.store_count, expected_stores, 20 * PROG_LEN);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: testbench/core_checker.sv
module core_checker (
    input logic        clk,
    input logic        rst_n,
    input logic        data_we,
    input logic        mem_valid,
    input logic [31:0] data_addr,
    input logic [31:0] data_out
);

    // Each entry is {write flag, address, data}
    logic [64:0] expected_q [$];
    int          error_count = 0;
    int          store_count = 0;

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        expected_q.push_back({1'b1, addr, data});
    endtask

    task automatic check_drained();
        if (expected_q.size() != 0) begin
            $display("%0d expected stores never appeared on the data port",
                     expected_q.size());
            error_count++;
        end
    endtask

    // Memory takes the write on this edge, so compare the values it sees
    always @(posedge clk) begin : compare_store
        logic [64:0] exp_entry;
        if (rst_n && data_we && mem_valid) begin
            if (expected_q.size() == 0) begin
                $display("Extra store to %h with data %h after the expected sequence ended",
                         data_addr, data_out);
                error_count++;
            end else begin
                exp_entry = expected_q.pop_front();
                if ({data_we, data_addr, data_out} !== exp_entry) begin
                    $display("ERROR store_seq #%0d: expected addr %h data %h, actual addr %h data %h",
                             store_count, exp_entry[63:32], exp_entry[31:0],
                             data_addr, data_out);
                    error_count++;
                end
            end
            store_count++;
        end
    end

endmodule

// File: hdl/pipeline_core.sv
`include "rv_fields.svh"

module pipeline_core (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic        fetch_valid,
    input  logic [31:0] data_in,
    input  logic        mem_valid,
    output logic [31:0] pc_out,
    output logic [31:0] data_addr,
    output logic [31:0] data_out,
    output logic        data_we
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [31:0] pc;
    logic [31:0] regfile [0:31];

    // Decode
    logic [31:0] dec_instr;
    logic [31:0] dec_imm;
    logic [31:0] dec_rs1_val;
    logic [31:0] dec_rs2_val;

    // EXEC stage
    alu_op_e     ex_alu_op;
    logic        ex_src_a_pc, ex_src_b_imm, ex_link;
    logic        ex_mem_write, ex_reg_write, ex_mem_to_reg, ex_branch, ex_jump;
    logic [2:0]  ex_funct3;
    logic [4:0]  ex_rs1, ex_rs2, ex_rd;
    logic [31:0] ex_pc, ex_imm, ex_rs1_val, ex_rs2_val;

    // MEM stage
    logic        ma_mem_write, ma_reg_write, ma_mem_to_reg;
    logic [2:0]  ma_funct3;
    logic [4:0]  ma_rd;
    logic [31:0] ma_alu_out, ma_store_val;
    logic        st_done;

    // WB stage
    logic        wb_reg_write, wb_mem_to_reg;
    logic [2:0]  wb_funct3;
    logic [4:0]  wb_rd;
    logic [31:0] wb_alu_out, wb_rd_word, wb_result, ld_value;

    logic [31:0] alu_out, store_val, target;
    logic        redirect, hold, fetch_stall, exec_bubble, exec_flush;
    fwd_sel_e    fwd_a, fwd_b;

    exec_ctrl_if dec_ctrl ();

    // Bubbles enter EXEC as a decoded NOP
    assign dec_instr = (exec_bubble || exec_flush) ? NOP_INSTR : instr;

    instr_decode u_decode (
        .instr (dec_instr),
        .imm   (dec_imm),
        .ctrl  (dec_ctrl.decode_mp)
    );

    // Read at decode with write-through from WB
    always_comb begin
        dec_rs1_val = regfile[`RS1(dec_instr)];
        if (`RS1(dec_instr) == REG_ZERO)
            dec_rs1_val = '0;
        else if (wb_reg_write && wb_rd == `RS1(dec_instr))
            dec_rs1_val = wb_result;
        dec_rs2_val = regfile[`RS2(dec_instr)];
        if (`RS2(dec_instr) == REG_ZERO)
            dec_rs2_val = '0;
        else if (wb_reg_write && wb_rd == `RS2(dec_instr))
            dec_rs2_val = wb_result;
    end

    always_ff @(posedge clk) begin
        if (wb_reg_write)
            regfile[wb_rd] <= wb_result;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem_write  <= 1'b0;
            ex_reg_write  <= 1'b0;
            ex_mem_to_reg <= 1'b0;
            ex_branch     <= 1'b0;
            ex_jump       <= 1'b0;
        end else if (!hold) begin
            ex_mem_write  <= dec_ctrl.mem_write;
            ex_reg_write  <= dec_ctrl.reg_write && `RD(dec_instr) != REG_ZERO;
            ex_mem_to_reg <= dec_ctrl.mem_to_reg;
            ex_branch     <= dec_ctrl.branch;
            ex_jump       <= dec_ctrl.jump;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_alu_op    <= dec_ctrl.alu_op;
            ex_src_a_pc  <= dec_ctrl.src_a_pc;
            ex_src_b_imm <= dec_ctrl.src_b_imm;
            ex_link      <= dec_ctrl.link;
            ex_funct3    <= `FUNCT3(dec_instr);
            ex_rs1       <= `RS1(dec_instr);
            ex_rs2       <= `RS2(dec_instr);
            ex_rd        <= `RD(dec_instr);
            ex_pc        <= pc;
            ex_imm       <= dec_imm;
            ex_rs1_val   <= dec_rs1_val;
            ex_rs2_val   <= dec_rs2_val;
        end
    end

    alu_execute u_execute (
        .alu_op    (ex_alu_op),
        .funct3    (ex_funct3),
        .src_a_pc  (ex_src_a_pc),
        .src_b_imm (ex_src_b_imm),
        .branch    (ex_branch),
        .jump      (ex_jump),
        .link      (ex_link),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .rs1_val   (ex_rs1_val),
        .rs2_val   (ex_rs2_val),
        .mem_val   (ma_alu_out),
        .wb_val    (wb_result),
        .pc        (ex_pc),
        .imm       (ex_imm),
        .alu_out   (alu_out),
        .store_val (store_val),
        .target    (target),
        .redirect  (redirect)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ma_mem_write  <= 1'b0;
            ma_reg_write  <= 1'b0;
            ma_mem_to_reg <= 1'b0;
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else if (!hold) begin
            ma_mem_write  <= ex_mem_write;
            ma_reg_write  <= ex_reg_write;
            ma_mem_to_reg <= ex_mem_to_reg;
            wb_reg_write  <= ma_reg_write;
            wb_mem_to_reg <= ma_mem_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ma_funct3    <= ex_funct3;
            ma_rd        <= ex_rd;
            ma_alu_out   <= alu_out;
            ma_store_val <= store_val;
            wb_funct3    <= ma_funct3;
            wb_rd        <= ma_rd;
            wb_alu_out   <= ma_alu_out;
            wb_rd_word   <= data_in;
        end
    end

    // Store already taken by memory while the front end is held
    always_ff @(posedge clk) begin
        if (!rst_n || !hold)
            st_done <= 1'b0;
        else if (data_we && mem_valid)
            st_done <= 1'b1;
    end

    load_store_align u_align (
        .st_funct3 (ma_funct3),
        .ld_funct3 (wb_funct3),
        .st_data   (ma_store_val),
        .rd_word   (wb_rd_word),
        .byte_sel  (wb_alu_out[1:0]),
        .wr_word   (data_out),
        .ld_value  (ld_value)
    );

    assign wb_result = wb_mem_to_reg ? ld_value : wb_alu_out;

    hazard_unit u_hazard (
        .mem_reg_write   (ma_reg_write),
        .wb_reg_write    (wb_reg_write),
        .exec_mem_to_reg (ex_mem_to_reg),
        .mem_is_access   (data_we || ma_mem_to_reg),
        .exec_rs1        (ex_rs1),
        .exec_rs2        (ex_rs2),
        .mem_rd          (ma_rd),
        .wb_rd           (wb_rd),
        .exec_rd         (ex_rd),
        .dec_rs1         (`RS1(instr)),
        .dec_rs2         (`RS2(instr)),
        .redirect        (redirect),
        .fetch_valid     (fetch_valid),
        .mem_valid       (mem_valid),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .hold            (hold),
        .fetch_stall     (fetch_stall),
        .exec_bubble     (exec_bubble),
        .exec_flush      (exec_flush)
    );

    always_ff @(posedge clk) begin
        if (!rst_n)
            pc <= '0;
        else if (!hold) begin
            if (redirect)
                pc <= target;
            else if (!fetch_stall)
                pc <= pc + 32'd4;
        end
    end

    assign pc_out    = pc;
    assign data_addr = ma_alu_out;
    assign data_we   = ma_mem_write && !st_done;

    // A store waits out back-pressure but is written exactly once
    assert property (@(posedge clk) disable iff (!rst_n)
        hold && data_we && !mem_valid |=> data_we)
        else $error("store dropped while memory stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        hold && data_we && mem_valid |=> !data_we)
        else $error("store repeated during hold");

endmodule

// File: hdl/hazard_unit.sv
module hazard_unit (
    input  logic               mem_reg_write,
    input  logic               wb_reg_write,
    input  logic               exec_mem_to_reg,
    input  logic               mem_is_access,
    input  logic [4:0]         exec_rs1,
    input  logic [4:0]         exec_rs2,
    input  logic [4:0]         mem_rd,
    input  logic [4:0]         wb_rd,
    input  logic [4:0]         exec_rd,
    input  logic [4:0]         dec_rs1,
    input  logic [4:0]         dec_rs2,
    input  logic               redirect,
    input  logic               fetch_valid,
    input  logic               mem_valid,
    output core_pkg::fwd_sel_e fwd_a,
    output core_pkg::fwd_sel_e fwd_b,
    output logic               hold,
    output logic               fetch_stall,
    output logic               exec_bubble,
    output logic               exec_flush
);
    import core_pkg::*;

    logic load_use;

    // Youngest producer wins, so MEM is checked before WB
    function automatic fwd_sel_e pick_src(input logic [4:0] rs,
                                          input logic m_we, input logic [4:0] m_rd,
                                          input logic w_we, input logic [4:0] w_rd);
        if (rs == REG_ZERO)
            return FWD_REGFILE;
        else if (m_we && m_rd == rs)
            return FWD_FROM_MEM;
        else if (w_we && w_rd == rs)
            return FWD_FROM_WB;
        else
            return FWD_REGFILE;
    endfunction

    assign fwd_a = pick_src(exec_rs1, mem_reg_write, mem_rd, wb_reg_write, wb_rd);
    assign fwd_b = pick_src(exec_rs2, mem_reg_write, mem_rd, wb_reg_write, wb_rd);

    assign load_use = exec_mem_to_reg && exec_rd != REG_ZERO &&
                      (exec_rd == dec_rs1 || exec_rd == dec_rs2);

    assign hold        = !fetch_valid || (mem_is_access && !mem_valid);
    assign fetch_stall = load_use && !redirect;
    assign exec_bubble = load_use;
    assign exec_flush  = redirect;

    // A load in EXEC can never redirect, so stall and flush never meet
    always_comb begin
        assert #0 (!(exec_mem_to_reg && redirect))
            else $error("load in EXEC raised a redirect");
    end

endmodule

// File: hdl/load_store_align.sv
module load_store_align (
    input  logic [2:0]  st_funct3,
    input  logic [2:0]  ld_funct3,
    input  logic [31:0] st_data,
    input  logic [31:0] rd_word,
    input  logic [1:0]  byte_sel,
    output logic [31:0] wr_word,
    output logic [31:0] ld_value
);
    import rv_isa_pkg::*;

    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    // No byte enables, so a sub-word store repeats across all lanes
    always_comb begin
        case (st_funct3)
            F3_BYTE: wr_word = {4{st_data[7:0]}};
            F3_HALF: wr_word = {2{st_data[15:0]}};
            F3_WORD: wr_word = st_data;
            default: wr_word = st_data;
        endcase
    end

    assign ld_byte = rd_word[{byte_sel, 3'b000} +: 8];
    assign ld_half = rd_word[{byte_sel[1], 4'b0000} +: 16];

    always_comb begin
        case (ld_funct3)
            F3_BYTE:   ld_value = {{24{ld_byte[7]}}, ld_byte};
            F3_BYTE_U: ld_value = {24'b0, ld_byte};
            F3_HALF:   ld_value = {{16{ld_half[15]}}, ld_half};
            F3_HALF_U: ld_value = {16'b0, ld_half};
            default:   ld_value = rd_word;
        endcase
    end

endmodule

// File: hdl/alu_execute.sv
module alu_execute (
    input  rv_isa_pkg::alu_op_e alu_op,
    input  logic [2:0]          funct3,
    input  logic                src_a_pc,
    input  logic                src_b_imm,
    input  logic                branch,
    input  logic                jump,
    input  logic                link,
    input  core_pkg::fwd_sel_e  fwd_a,
    input  core_pkg::fwd_sel_e  fwd_b,
    input  logic [31:0]         rs1_val,
    input  logic [31:0]         rs2_val,
    input  logic [31:0]         mem_val,
    input  logic [31:0]         wb_val,
    input  logic [31:0]         pc,
    input  logic [31:0]         imm,
    output logic [31:0]         alu_out,
    output logic [31:0]         store_val,
    output logic [31:0]         target,
    output logic                redirect
);
    import rv_isa_pkg::*;
    import core_pkg::*;

    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] result;
    logic        taken;

    function automatic logic [31:0] forward(input fwd_sel_e sel, input logic [31:0] reg_val,
                                            input logic [31:0] m_val, input logic [31:0] w_val);
        case (sel)
            FWD_FROM_MEM: return m_val;
            FWD_FROM_WB:  return w_val;
            default:      return reg_val;
        endcase
    endfunction

    assign src1      = forward(fwd_a, rs1_val, mem_val, wb_val);
    assign src2      = forward(fwd_b, rs2_val, mem_val, wb_val);
    assign op_a      = src_a_pc ? pc : src1;
    assign op_b      = src_b_imm ? imm : src2;
    assign store_val = src2;

    always_comb begin
        case (alu_op)
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << op_b[4:0];
            ALU_SLT:    result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   result = {31'b0, op_a < op_b};
            ALU_XOR:    result = op_a ^ op_b;
            ALU_SRL:    result = op_a >> op_b[4:0];
            ALU_SRA:    result = $signed(op_a) >>> op_b[4:0];
            ALU_OR:     result = op_a | op_b;
            ALU_AND:    result = op_a & op_b;
            ALU_PASS_B: result = op_b;
            default:    result = op_a + op_b;
        endcase
    end

    assign alu_out = link ? pc + 32'd4 : result;

    // Branch conditions work on the forwarded registers, never on the immediate
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = src1 == src2;
            F3_BNE:  taken = src1 != src2;
            F3_BLT:  taken = $signed(src1) < $signed(src2);
            F3_BGE:  taken = $signed(src1) >= $signed(src2);
            F3_BLTU: taken = src1 < src2;
            F3_BGEU: taken = src1 >= src2;
            default: taken = 1'b0;
        endcase
    end

    assign target   = pc + imm;
    assign redirect = jump || (branch && taken);

endmodule

// File: hdl/instr_decode.sv
`include "rv_fields.svh"

module instr_decode (
    input  logic [31:0]     instr,
    output logic [31:0]     imm,
    exec_ctrl_if.decode_mp  ctrl
);
    import rv_isa_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    alu_op_e    arith_op;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = `FUNCT3(instr);
    assign funct7 = `FUNCT7(instr);

    // funct7[5] only selects SUB for register-register ops
    always_comb begin
        case (funct3)
            F3_ADD:  arith_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  arith_op = ALU_SLL;
            F3_SLT:  arith_op = ALU_SLT;
            F3_SLTU: arith_op = ALU_SLTU;
            F3_XOR:  arith_op = ALU_XOR;
            F3_SRL:  arith_op = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        imm             = '0;
        ctrl.alu_op     = ALU_ADD;
        ctrl.src_a_pc   = 1'b0;
        ctrl.src_b_imm  = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.jump       = 1'b0;
        ctrl.link       = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = arith_op;
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                imm            = {{20{instr[31]}}, instr[31:20]};
                ctrl.alu_op    = arith_op;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_LOAD: begin
                imm             = {{20{instr[31]}}, instr[31:20]};
                ctrl.src_b_imm  = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OPC_STORE: begin
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                ctrl.src_b_imm = 1'b1;
                ctrl.mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                imm         = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                               instr[11:8], 1'b0};
                ctrl.branch = 1'b1;
            end
            OPC_JAL: begin
                imm            = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
                ctrl.jump      = 1'b1;
                ctrl.link      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_LUI: begin
                imm            = {instr[31:12], 12'b0};
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_AUIPC: begin
                imm            = {instr[31:12], 12'b0};
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            // Unknown opcode falls through as a NOP
            default: ;
        endcase
    end

    always_comb begin
        assert #0 (!(ctrl.mem_write && ctrl.reg_write))
            else $error("decode asserts both mem_write and reg_write");
    end

endmodule

// File: hdl/exec_ctrl_if.sv
interface exec_ctrl_if;
    import rv_isa_pkg::*;

    alu_op_e alu_op;
    logic    src_a_pc;
    logic    src_b_imm;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
    logic    branch;
    logic    jump;
    // Result is pc+4 rather than the ALU value
    logic    link;

    modport decode_mp (
        output alu_op,
        output src_a_pc,
        output src_b_imm,
        output mem_write,
        output reg_write,
        output mem_to_reg,
        output branch,
        output jump,
        output link
    );

    modport pipe_mp (
        input alu_op,
        input src_a_pc,
        input src_b_imm,
        input mem_write,
        input reg_write,
        input mem_to_reg,
        input branch,
        input jump,
        input link
    );

endinterface

// File: hdl/core_pkg.sv
package core_pkg;

    // Source of an ALU operand in EXEC
    typedef enum logic [1:0] {
        FWD_REGFILE,
        FWD_FROM_MEM,
        FWD_FROM_WB
    } fwd_sel_e;

    localparam logic [4:0] REG_ZERO = 5'd0;

    // ADDI x0,x0,0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111
    } opcode_e;

    // Arithmetic funct3, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SRL  = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Load and store width
    localparam logic [2:0] F3_BYTE   = 3'b000;
    localparam logic [2:0] F3_HALF   = 3'b001;
    localparam logic [2:0] F3_WORD   = 3'b010;
    localparam logic [2:0] F3_BYTE_U = 3'b100;
    localparam logic [2:0] F3_HALF_U = 3'b101;

    // Branch conditions
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

endpackage

// File: include/rv_fields.svh
`ifndef RV_FIELDS_SVH
`define RV_FIELDS_SVH

// Argument must be a plain signal name
`define RD(w)     w[11:7]
`define RS1(w)    w[19:15]
`define RS2(w)    w[24:20]
`define FUNCT3(w) w[14:12]
`define FUNCT7(w) w[31:25]

`endif
